//--- Makefile
TOP = comb_spec_alloc_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb.f
+incdir+verilog
verilog/noc_alloc_pkg.sv
verilog/spec_grant_if.sv
verilog/rr_arbiter.sv
verilog/sw_alloc_stage.sv
verilog/spec_sw_alloc.sv
verilog/vc_alloc.sv
verilog/comb_spec_alloc.sv
verification/comb_spec_alloc_checker.sv
verification/comb_spec_alloc_tb.sv

//--- verification/comb_spec_alloc_checker.sv
`timescale 1ns/10ps
`default_nettype none

module comb_spec_alloc_checker
    import noc_alloc_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input ivc_mask_t  ns_ivc_grant,
    input ivc_mask_t  sp_ivc_ok,
    input port_dest_t granted_dest_port
);

    for (genvar i = 0; i < port_count; i++) begin : g_in
        // an input port is granted by one stage at most
        a_stage_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
            !((|ns_ivc_grant[i]) && (|sp_ivc_ok[i])))
            else $error("input port %0d granted by both switch stages", i);

        a_dest_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(granted_dest_port[i]))
            else $error("more than one destination granted to input %0d", i);
    end

    // one input per output, so each ovc_allocated bit has a single source
    for (genvar o = 0; o < port_count; o++) begin : g_out
        port_mask_t takers;  // inputs granted this output

        always_comb begin
            takers = '0;
            for (int i = 0; i < port_count; i++) begin
                if (i != o) begin
                    takers[i] = granted_dest_port[i][sel_bit(i, o)];
                end
            end
        end

        a_one_input: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(takers))
            else $error("output %0d granted to more than one input", o);
    end

endmodule

bind spec_sw_alloc comb_spec_alloc_checker i_checker (
    .clk              (clk),
    .rst_n            (rst_n),
    .ns_ivc_grant     (ns_ivc_grant),
    .sp_ivc_ok        (sp_ivc_ok),
    .granted_dest_port(granted_dest_port)
);

`default_nettype wire

//--- verification/comb_spec_alloc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module comb_spec_alloc_tb
    import noc_alloc_pkg::*;
();

    localparam int clk_period    = 4;
    localparam int tests_planned = 6;
    localparam int test_cycles   = 16;  // upper bound per test, reset included

    logic       clk;
    logic       rst_n;
    ivc_mask_t  ivc_request;
    ivc_mask_t  ovc_is_assigned;
    ivc_mask_t  assigned_ovc_not_full;
    dest_all_t  dest_port;
    cand_ovc_t  cand_ovc;
    ivc_mask_t  ivc_sw_grant;
    port_dest_t granted_dest_port;
    port_mask_t any_sw_grant;
    ivc_mask_t  ivc_ovc_grant;
    vc_mask_t [port_count-1:0] granted_ovc;
    ivc_mask_t  ovc_allocated;

    // expected responses
    ivc_mask_t  exp_sw;
    port_dest_t exp_dest;
    port_mask_t exp_any;
    ivc_mask_t  exp_ovc;
    ivc_mask_t  exp_gov;
    ivc_mask_t  exp_alloc;

    int err_count;
    int test_err;
    int tests_run;
    int tests_failed;

    comb_spec_alloc i_comb_spec_alloc (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ivc_request          (ivc_request),
        .ovc_is_assigned      (ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full),
        .dest_port            (dest_port),
        .cand_ovc             (cand_ovc),
        .ivc_sw_grant         (ivc_sw_grant),
        .granted_dest_port    (granted_dest_port),
        .any_sw_grant         (any_sw_grant),
        .ivc_ovc_grant        (ivc_ovc_grant),
        .granted_ovc          (granted_ovc),
        .ovc_allocated        (ovc_allocated)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((tests_planned * test_cycles + 20) * clk_period);
        $display("watchdog: tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    // bit m of input src means output m below src, m+1 otherwise
    function automatic port_sel_t route(input int src, input int dst);
        port_sel_t sel;
        sel = '0;
        for (int m = 0; m < sel_count; m++) begin
            if (((m < src) ? m : m + 1) == dst) sel[m] = 1'b1;
        end
        return sel;
    endfunction

    function automatic vc_mask_t lowest(input vc_mask_t m);
        vc_mask_t r;
        r = '0;
        for (int j = vc_count - 1; j >= 0; j--) begin
            if (m[j]) begin
                r    = '0;
                r[j] = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic int pick(input int n);
        return int'($urandom_range(n - 1, 0));
    endfunction

    function automatic int pick_other(input int a, input int b);
        int p;
        do p = pick(port_count); while (p == a || p == b);
        return p;
    endfunction

    task automatic check_ivc(input string name, input ivc_mask_t got, input ivc_mask_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_dest(input string name, input port_dest_t got, input port_dest_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_ports(input string name, input port_mask_t got, input port_mask_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_vc(input string name, input vc_mask_t got, input vc_mask_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_outputs();
        check_ivc("ivc_sw_grant", ivc_sw_grant, exp_sw);
        check_dest("granted_dest_port", granted_dest_port, exp_dest);
        check_ports("any_sw_grant", any_sw_grant, exp_any);
        check_ivc("ivc_ovc_grant", ivc_ovc_grant, exp_ovc);
        for (int i = 0; i < port_count; i++) begin
            check_vc($sformatf("granted_ovc[%0d]", i), granted_ovc[i], exp_gov[i]);
        end
        check_ivc("ovc_allocated", ovc_allocated, exp_alloc);
    endtask

    task automatic clear_expected();
        exp_sw    = '0;
        exp_dest  = '0;
        exp_any   = '0;
        exp_ovc   = '0;
        exp_gov   = '0;
        exp_alloc = '0;
    endtask

    task automatic expect_sw(input int p, input int v, input int d);
        exp_sw[p][v] = 1'b1;
        exp_dest[p]  = route(p, d);
        exp_any[p]   = 1'b1;
    endtask

    task drive_idle();
        ivc_request           <= '0;
        ovc_is_assigned       <= '0;
        assigned_ovc_not_full <= '0;
        dest_port             <= '0;
        cand_ovc              <= '0;
    endtask

    // ivc already holding an ovc
    task drive_ns(input int p, input int v, input int d, input bit not_full);
        ivc_request[p][v]           <= 1'b1;
        ovc_is_assigned[p][v]       <= 1'b1;
        assigned_ovc_not_full[p][v] <= not_full;
        dest_port[p][v]             <= route(p, d);
    endtask

    // ivc still looking for an ovc
    task drive_spec(input int p, input int v, input int d, input vc_mask_t cand);
        ivc_request[p][v] <= 1'b1;
        dest_port[p][v]   <= route(p, d);
        cand_ovc[p][v]    <= cand;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst_n <= 1'b0;
        drive_idle();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        err_count += test_err;
        if (test_err == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, test_err);
            tests_failed++;
        end
        test_err = 0;
    endtask

    task automatic test_idle();
        reset_dut();
        @(posedge clk);
        drive_idle();
        clear_expected();
        @(negedge clk);
        check_outputs();
        finish_test("idle after reset");
    endtask

    task automatic test_nonspec();
        int p;
        int v;
        int d;
        p = pick(port_count);
        v = pick(vc_count);
        d = pick_other(p, p);
        reset_dut();
        @(posedge clk);
        drive_ns(p, v, d, 1'b1);
        clear_expected();
        expect_sw(p, v, d);
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        drive_ns(p, v, d, 1'b0);  // full ovc, request drops out
        clear_expected();
        @(negedge clk);
        check_outputs();
        finish_test("non-speculative grant");
    endtask

    task automatic test_rr_contention();
        int a;
        int b;
        int d;
        int lo;
        int hi;
        int va;
        int vb;
        a  = pick(port_count);
        b  = pick_other(a, a);
        d  = pick_other(a, b);
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        va = pick(vc_count);
        vb = pick(vc_count);
        reset_dut();
        @(posedge clk);
        drive_ns(lo, va, d, 1'b1);
        drive_ns(hi, vb, d, 1'b1);
        for (int k = 0; k < 4; k++) begin
            clear_expected();
            if (k % 2 == 0) expect_sw(lo, va, d);
            else expect_sw(hi, vb, d);
            @(negedge clk);
            check_outputs();
            @(posedge clk);
        end
        finish_test("round-robin output contention");
    endtask

    task automatic test_spec();
        int       p;
        int       v;
        int       d;
        vc_mask_t cand;
        p    = pick(port_count);
        v    = pick(vc_count);
        d    = pick_other(p, p);
        cand = vc_mask_t'($urandom_range((1 << vc_count) - 1, 1));
        reset_dut();
        @(posedge clk);
        drive_spec(p, v, d, cand);
        clear_expected();
        expect_sw(p, v, d);
        exp_ovc[p][v] = 1'b1;
        exp_gov[p]    = lowest(cand);  // ovc pointer at 0 after reset
        exp_alloc[d]  = lowest(cand);
        @(negedge clk);
        check_outputs();
        finish_test("speculative grant");
    endtask

    task automatic test_ns_priority();
        int p;
        int q;
        int d;
        int vs;
        int vn;
        p  = pick(port_count);
        q  = pick_other(p, p);
        d  = pick_other(p, q);
        vs = pick(vc_count);
        vn = (vs + 1 + pick(vc_count - 1)) % vc_count;
        reset_dut();
        // same input port
        @(posedge clk);
        drive_idle();
        drive_spec(p, vs, d, '1);
        drive_ns(p, vn, q, 1'b1);
        clear_expected();
        expect_sw(p, vn, q);
        @(negedge clk);
        check_outputs();
        // same output port
        @(posedge clk);
        drive_idle();
        drive_spec(p, vs, d, '1);
        drive_ns(q, vn, d, 1'b1);
        clear_expected();
        expect_sw(q, vn, d);
        @(negedge clk);
        check_outputs();
        finish_test("non-speculative priority");
    endtask

    task automatic test_no_free_ovc();
        int p;
        int v;
        int d;
        p = pick(port_count);
        v = pick(vc_count);
        d = pick_other(p, p);
        reset_dut();
        @(posedge clk);
        drive_spec(p, v, d, '0);
        clear_expected();
        @(negedge clk);
        check_outputs();
        finish_test("no free ovc");
    endtask

    initial begin
        void'($urandom(29644));
        rst_n                 = 1'b0;
        ivc_request           = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
        dest_port             = '0;
        cand_ovc              = '0;
        err_count             = 0;
        test_err              = 0;
        tests_run             = 0;
        tests_failed          = 0;
        test_idle();
        test_nonspec();
        test_rr_contention();
        test_spec();
        test_ns_priority();
        test_no_free_ovc();
        $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/comb_spec_alloc.sv
`timescale 1ns/10ps
`default_nettype none

module comb_spec_alloc
    import noc_alloc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  ivc_mask_t                 ivc_request,
    input  ivc_mask_t                 ovc_is_assigned,
    input  ivc_mask_t                 assigned_ovc_not_full,
    input  dest_all_t                 dest_port,
    input  cand_ovc_t                 cand_ovc,
    output ivc_mask_t                 ivc_sw_grant,
    output port_dest_t                granted_dest_port,
    output port_mask_t                any_sw_grant,
    output ivc_mask_t                 ivc_ovc_grant,
    output vc_mask_t [port_count-1:0] granted_ovc,
    output ivc_mask_t                 ovc_allocated
);

    // speculative results from switch to vc allocator
    spec_grant_if i_spec_grant_if ();

    spec_sw_alloc i_spec_sw_alloc (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ivc_request          (ivc_request),
        .ovc_is_assigned      (ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full),
        .dest_port            (dest_port),
        .ivc_sw_grant         (ivc_sw_grant),
        .granted_dest_port    (granted_dest_port),
        .any_sw_grant         (any_sw_grant),
        .sg                   (i_spec_grant_if.sw)
    );

    vc_alloc i_vc_alloc (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand_ovc     (cand_ovc),
        .ivc_ovc_grant(ivc_ovc_grant),
        .granted_ovc  (granted_ovc),
        .ovc_allocated(ovc_allocated),
        .sg           (i_spec_grant_if.vc)
    );

endmodule

`default_nettype wire

//--- verilog/noc_alloc_params.svh
`ifndef NOC_ALLOC_PARAMS_SVH
`define NOC_ALLOC_PARAMS_SVH

// router ports, local port included
`define NOC_P 5

// virtual channels per port
`define NOC_V 4

`endif

//--- verilog/noc_alloc_pkg.sv
`include "noc_alloc_params.svh"
`default_nettype none

package noc_alloc_pkg;

    localparam int port_count = `NOC_P;
    localparam int vc_count   = `NOC_V;
    localparam int sel_count  = `NOC_P - 1;  // a port never routes back to itself

    typedef logic [vc_count-1:0]   vc_mask_t;
    typedef logic [sel_count-1:0]  port_sel_t;
    typedef logic [port_count-1:0] port_mask_t;

    // indexed by port, then by vc
    typedef vc_mask_t  [port_count-1:0] ivc_mask_t;
    typedef port_sel_t [port_count-1:0] port_dest_t;
    typedef port_sel_t [port_count-1:0][vc_count-1:0] dest_all_t;
    typedef vc_mask_t  [port_count-1:0][vc_count-1:0] cand_ovc_t;

    // position of port other inside the destination vector of port own
    function automatic int sel_bit(input int own, input int other);
        return (other < own) ? other : other - 1;
    endfunction

endpackage

`default_nettype wire

//--- verilog/rr_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] request,
    output logic [width-1:0] grant,
    output logic             any_grant
);

    localparam int ptr_w = (width > 1) ? $clog2(width) : 1;

    logic [ptr_w-1:0] ptr;       // index with highest priority
    logic [ptr_w-1:0] next_ptr;

    // circular search starting at the pointer
    always_comb begin
        int   idx;
        logic found;
        idx      = 0;
        found    = 1'b0;
        grant    = '0;
        next_ptr = ptr;
        for (int k = 0; k < width; k++) begin
            idx = (int'(ptr) + k) % width;
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                next_ptr   = ptr_w'((idx + 1) % width);  // winner goes last
                found      = 1'b1;
            end
        end
    end

    assign any_grant = |grant;

    // pointer only moves on a real grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (any_grant) begin
            ptr <= next_ptr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/spec_grant_if.sv
`timescale 1ns/10ps
`default_nettype none

interface spec_grant_if
    import noc_alloc_pkg::*;
();

    ivc_mask_t  valid_speculation;  // ivc has at least one free candidate ovc
    ivc_mask_t  spec_first_grant;   // masked first-level speculative winners
    port_dest_t spec_granted_dest;  // accepted speculative destinations only
    port_mask_t spec_grant_valid;

    modport sw (
        input  valid_speculation,
        output spec_first_grant,
        output spec_granted_dest,
        output spec_grant_valid
    );

    modport vc (
        output valid_speculation,
        input  spec_first_grant,
        input  spec_granted_dest,
        input  spec_grant_valid
    );

endinterface

`default_nettype wire

//--- verilog/spec_sw_alloc.sv
`timescale 1ns/10ps
`default_nettype none

module spec_sw_alloc
    import noc_alloc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ivc_mask_t  ivc_request,
    input  ivc_mask_t  ovc_is_assigned,
    input  ivc_mask_t  assigned_ovc_not_full,
    input  dest_all_t  dest_port,
    output ivc_mask_t  ivc_sw_grant,
    output port_dest_t granted_dest_port,
    output port_mask_t any_sw_grant,
    spec_grant_if.sw   sg
);

    ivc_mask_t  ns_request;
    ivc_mask_t  sp_request;
    ivc_mask_t  ns_ivc_grant;
    ivc_mask_t  sp_ivc_grant;
    ivc_mask_t  sp_first_grant;
    port_dest_t ns_dest;
    port_dest_t sp_dest;
    port_mask_t ns_inport;
    port_mask_t ns_outport;
    port_dest_t sp_dest_ok;    // speculative grants surviving the merge
    port_mask_t sp_valid;
    ivc_mask_t  sp_ivc_ok;

    // ivcs holding an ovc go non-speculative
    assign ns_request = ivc_request & ovc_is_assigned;
    assign sp_request = ivc_request & ~ovc_is_assigned;

    sw_alloc_stage #(
        .speculative(1'b0)
    ) i_nonspec (
        .clk            (clk),
        .rst_n          (rst_n),
        .request        (ns_request),
        .qualify        (assigned_ovc_not_full),
        .dest_port      (dest_port),
        .ivc_grant      (ns_ivc_grant),
        .first_grant    (),
        .granted_dest   (ns_dest),
        .inport_granted (ns_inport),
        .outport_granted(ns_outport)
    );

    sw_alloc_stage #(
        .speculative(1'b1)
    ) i_spec (
        .clk            (clk),
        .rst_n          (rst_n),
        .request        (sp_request),
        .qualify        (sg.valid_speculation),
        .dest_port      (dest_port),
        .ivc_grant      (sp_ivc_grant),
        .first_grant    (sp_first_grant),
        .granted_dest   (sp_dest),
        .inport_granted (),
        .outport_granted()
    );

    // non-speculative grants win on both the input and the output side
    always_comb begin
        port_sel_t blocked;
        blocked    = '0;
        sp_dest_ok = '0;
        for (int i = 0; i < port_count; i++) begin
            blocked = '0;
            for (int o = 0; o < port_count; o++) begin
                if (o != i) begin
                    blocked[sel_bit(i, o)] = ns_outport[o];
                end
            end
            if (!ns_inport[i]) begin
                sp_dest_ok[i] = sp_dest[i] & ~blocked;
            end
        end
    end

    for (genvar i = 0; i < port_count; i++) begin : g_accept
        assign sp_valid[i]  = |sp_dest_ok[i];
        assign sp_ivc_ok[i] = sp_valid[i] ? sp_ivc_grant[i] : '0;
    end

    assign sg.spec_first_grant  = sp_first_grant;
    assign sg.spec_granted_dest = sp_dest_ok;
    assign sg.spec_grant_valid  = sp_valid;

    assign ivc_sw_grant      = ns_ivc_grant | sp_ivc_ok;
    assign granted_dest_port = ns_dest | sp_dest_ok;
    assign any_sw_grant      = ns_inport | sp_valid;

endmodule

`default_nettype wire

//--- verilog/sw_alloc_stage.sv
`timescale 1ns/10ps
`default_nettype none

module sw_alloc_stage
    import noc_alloc_pkg::*;
#(
    parameter bit speculative = 1'b0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ivc_mask_t  request,
    input  ivc_mask_t  qualify,
    input  dest_all_t  dest_port,
    output ivc_mask_t  ivc_grant,
    output ivc_mask_t  first_grant,
    output port_dest_t granted_dest,
    output port_mask_t inport_granted,
    output port_mask_t outport_granted
);

    ivc_mask_t  in_req;
    ivc_mask_t  in_grant;     // raw input arbiter winners
    port_dest_t winner_dest;  // destination of each input winner
    port_dest_t out_req;      // indexed by output port
    port_dest_t out_grant;

    for (genvar i = 0; i < port_count; i++) begin : g_port
        if (speculative) begin : g_spec
            assign in_req[i]      = request[i];
            // winner without a free candidate ovc is dropped here
            assign first_grant[i] = in_grant[i] & qualify[i];
        end else begin : g_nonspec
            assign in_req[i]      = request[i] & qualify[i];  // full ovc removes request
            assign first_grant[i] = in_grant[i];
        end

        // one ivc per input port
        rr_arbiter #(
            .width(vc_count)
        ) i_in_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (in_req[i]),
            .grant    (in_grant[i]),
            .any_grant()
        );

        // one input port per output port
        rr_arbiter #(
            .width(sel_count)
        ) i_out_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (out_req[i]),
            .grant    (out_grant[i]),
            .any_grant(outport_granted[i])
        );

        assign inport_granted[i] = |granted_dest[i];
        assign ivc_grant[i]      = inport_granted[i] ? first_grant[i] : '0;
    end

    // one-hot mux of the winner's destination
    always_comb begin
        winner_dest = '0;
        for (int i = 0; i < port_count; i++) begin
            for (int j = 0; j < vc_count; j++) begin
                if (first_grant[i][j]) begin
                    winner_dest[i] = winner_dest[i] | dest_port[i][j];
                end
            end
        end
    end

    // input to output crossing and back, own port skipped
    always_comb begin
        out_req      = '0;
        granted_dest = '0;
        for (int o = 0; o < port_count; o++) begin
            for (int i = 0; i < port_count; i++) begin
                if (i != o) begin
                    out_req[o][sel_bit(o, i)]      = winner_dest[i][sel_bit(i, o)];
                    granted_dest[i][sel_bit(i, o)] = out_grant[o][sel_bit(o, i)];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/vc_alloc.sv
`timescale 1ns/10ps
`default_nettype none

module vc_alloc
    import noc_alloc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  cand_ovc_t                 cand_ovc,
    output ivc_mask_t                 ivc_ovc_grant,
    output vc_mask_t [port_count-1:0] granted_ovc,
    output ivc_mask_t                 ovc_allocated,  // by output port, then ovc
    spec_grant_if.vc                  sg
);

    ivc_mask_t ovc_req;  // candidate ovcs of the first-level winner
    ivc_mask_t ovc_win;

    always_comb begin
        sg.valid_speculation = '0;
        ovc_req              = '0;
        for (int i = 0; i < port_count; i++) begin
            for (int j = 0; j < vc_count; j++) begin
                sg.valid_speculation[i][j] = |cand_ovc[i][j];
                if (sg.spec_first_grant[i][j]) begin
                    ovc_req[i] = ovc_req[i] | cand_ovc[i][j];
                end
            end
        end
    end

    for (genvar i = 0; i < port_count; i++) begin : g_port
        // picks one ovc out of the candidates
        rr_arbiter #(
            .width(vc_count)
        ) i_ovc_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (ovc_req[i]),
            .grant    (ovc_win[i]),
            .any_grant()
        );

        // only kept when the speculative switch grant survived
        assign granted_ovc[i]   = sg.spec_grant_valid[i] ? ovc_win[i] : '0;
        assign ivc_ovc_grant[i] = sg.spec_grant_valid[i] ? sg.spec_first_grant[i] : '0;
    end

    // route the won ovc to its output port
    always_comb begin
        ovc_allocated = '0;
        for (int o = 0; o < port_count; o++) begin
            for (int i = 0; i < port_count; i++) begin
                if (i != o && sg.spec_granted_dest[i][sel_bit(i, o)]) begin
                    ovc_allocated[o] = ovc_allocated[o] | granted_ovc[i];
                end
            end
        end
    end

endmodule

`default_nettype wire
